/* rtl/tomasulo_pkg.sv */
package tomasulo_pkg;

  parameter int XLEN  = 32;
  parameter int TAG_W = 4;  // 16 tags in flight at most

  parameter int RS_DEPTH_DEFAULT   = 4;
  parameter int MUL_STAGES_DEFAULT = 3;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic signed [XLEN-1:0] data_t;

  // ready=1 means value holds, ready=0 means wait for tag
  typedef struct packed {
    logic  ready;
    tag_t  tag;
    data_t value;
  } operand_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,  // shift amount from low 5 bits of b
    ALU_SRL,
    ALU_SLT
  } alu_op_t;

  typedef struct packed {
    alu_op_t op;
  } alu_payload_t;

  typedef struct packed {
    logic high;  // reserved, upper half select
  } mul_payload_t;

  typedef struct packed {
    logic         valid;
    tag_t         tag;
    operand_t     src1;
    operand_t     src2;
    alu_payload_t payload;
  } alu_issue_t;

  typedef struct packed {
    logic         valid;
    tag_t         tag;
    operand_t     src1;
    operand_t     src2;
    mul_payload_t payload;
  } mul_issue_t;

  // common data bus broadcast
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    data_t data;
  } cdb_t;

endpackage

/* rtl/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station import tomasulo_pkg::*; #(
  parameter type payload_t = alu_payload_t,
  parameter int  DEPTH     = RS_DEPTH_DEFAULT
) (
  input  logic     clk_100mhz,
  input  logic     sys_rst,
  input  logic     i_issue_valid,
  input  tag_t     i_tag,
  input  operand_t i_src1,
  input  operand_t i_src2,
  input  payload_t i_payload,
  input  cdb_t     i_cdb,
  input  logic     i_fu_ready,
  output logic     o_ready,
  output logic     o_disp_valid,
  output tag_t     o_disp_tag,
  output data_t    o_disp_a,
  output data_t    o_disp_b,
  output payload_t o_disp_payload
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef struct packed {
    tag_t     tag;
    operand_t src1;
    operand_t src2;
    payload_t payload;
  } entry_t;

  logic [DEPTH-1:0] busy;
  entry_t           slots [DEPTH];

  logic             free_found;
  logic [IDX_W-1:0] free_idx;
  logic             sel_found;
  logic [IDX_W-1:0] sel_idx;
  logic             issue_fire;
  logic             disp_fire;

  // capture a pending operand when its producer shows up on the bus
  function automatic operand_t wake(operand_t op, cdb_t cdb);
    operand_t res;
    res = op;
    if (!op.ready && cdb.valid && (cdb.tag == op.tag)) begin
      res.ready = 1'b1;
      res.value = cdb.data;
    end
    return res;
  endfunction

  // lowest free slot and lowest eligible entry
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    sel_found  = 1'b0;
    sel_idx    = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_found = 1'b1;
        free_idx   = IDX_W'(i);
      end
      if (busy[i] && slots[i].src1.ready && slots[i].src2.ready) begin
        sel_found = 1'b1;
        sel_idx   = IDX_W'(i);
      end
    end
  end

  assign o_ready    = free_found;
  assign issue_fire = i_issue_valid && free_found;
  assign disp_fire  = sel_found && i_fu_ready;

  assign o_disp_valid   = disp_fire;
  assign o_disp_tag     = slots[sel_idx].tag;
  assign o_disp_a       = slots[sel_idx].src1.value;
  assign o_disp_b       = slots[sel_idx].src2.value;
  assign o_disp_payload = slots[sel_idx].payload;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
    end else begin
      if (disp_fire) busy[sel_idx] <= 1'b0;  // slot frees at dispatch edge
      if (issue_fire) busy[free_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < DEPTH; i++) begin
      slots[i].src1 <= wake(slots[i].src1, i_cdb);
      slots[i].src2 <= wake(slots[i].src2, i_cdb);
    end
    // incoming op also snoops the bus in its issue cycle
    if (issue_fire) begin
      slots[free_idx].tag     <= i_tag;
      slots[free_idx].src1    <= wake(i_src1, i_cdb);
      slots[free_idx].src2    <= wake(i_src2, i_cdb);
      slots[free_idx].payload <= i_payload;
    end
  end

endmodule

/* rtl/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit import tomasulo_pkg::*; (
  input  logic         clk_100mhz,
  input  logic         sys_rst,
  input  logic         i_valid,
  input  tag_t         i_tag,
  input  data_t        i_a,
  input  data_t        i_b,
  input  alu_payload_t i_payload,
  input  logic         i_grant,
  output logic         o_ready,
  output logic         o_valid,
  output tag_t         o_tag,
  output data_t        o_result
);

  data_t alu_out;

  always_comb begin
    case (i_payload.op)
      ALU_ADD: alu_out = i_a + i_b;
      ALU_SUB: alu_out = i_a - i_b;
      ALU_AND: alu_out = i_a & i_b;
      ALU_OR:  alu_out = i_a | i_b;
      ALU_XOR: alu_out = i_a ^ i_b;
      ALU_SLL: alu_out = i_a << i_b[4:0];
      ALU_SRL: alu_out = data_t'($unsigned(i_a) >> i_b[4:0]);  // logical
      ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, (i_a < i_b)};       // signed compare
      default: alu_out = '0;
    endcase
  end

  // free when empty or the held result leaves this cycle
  assign o_ready = !o_valid || i_grant;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_valid <= 1'b0;
    end else if (i_valid && o_ready) begin
      o_valid <= 1'b1;
    end else if (i_grant) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_valid && o_ready) begin
      o_tag    <= i_tag;
      o_result <= alu_out;
    end
  end

endmodule

/* rtl/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit import tomasulo_pkg::*; #(
  parameter int STAGES = MUL_STAGES_DEFAULT
) (
  input  logic  clk_100mhz,
  input  logic  sys_rst,
  input  logic  i_valid,
  input  tag_t  i_tag,
  input  data_t i_a,
  input  data_t i_b,
  input  logic  i_grant,
  output logic  o_ready,
  output logic  o_valid,
  output tag_t  o_tag,
  output data_t o_result
);

  logic [STAGES-1:0] pipe_valid;
  tag_t              pipe_tag  [STAGES];
  data_t             pipe_prod [STAGES];
  logic              advance;
  data_t             product;

  // low word of the signed product
  assign product = data_t'(i_a * i_b);

  // whole pipe holds while the last stage waits for the bus
  assign advance = !(pipe_valid[STAGES-1] && !i_grant);
  assign o_ready = advance;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      pipe_valid <= '0;
    end else if (advance) begin
      pipe_valid[0] <= i_valid;
      for (int s = 1; s < STAGES; s++) begin
        pipe_valid[s] <= pipe_valid[s-1];
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (advance) begin
      pipe_tag[0]  <= i_tag;
      pipe_prod[0] <= product;
      for (int s = 1; s < STAGES; s++) begin
        pipe_tag[s]  <= pipe_tag[s-1];
        pipe_prod[s] <= pipe_prod[s-1];
      end
    end
  end

  assign o_valid  = pipe_valid[STAGES-1];
  assign o_tag    = pipe_tag[STAGES-1];
  assign o_result = pipe_prod[STAGES-1];

endmodule

/* rtl/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter import tomasulo_pkg::*; (
  input  logic  clk_100mhz,
  input  logic  sys_rst,
  input  logic  i_alu_valid,
  input  tag_t  i_alu_tag,
  input  data_t i_alu_result,
  input  logic  i_mul_valid,
  input  tag_t  i_mul_tag,
  input  data_t i_mul_result,
  output logic  o_alu_grant,
  output logic  o_mul_grant,
  output cdb_t  o_cdb
);

  // fixed priority, alu wins
  assign o_alu_grant = i_alu_valid;
  assign o_mul_grant = i_mul_valid && !i_alu_valid;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_cdb.valid <= 1'b0;
    end else begin
      o_cdb.valid <= o_alu_grant || o_mul_grant;  // one cycle per grant
    end
    if (o_alu_grant) begin
      o_cdb.tag  <= i_alu_tag;
      o_cdb.data <= i_alu_result;
    end else begin
      o_cdb.tag  <= i_mul_tag;
      o_cdb.data <= i_mul_result;
    end
  end

endmodule

/* rtl/tomasulo_core.sv */
`timescale 1ns/1ps

module tomasulo_core import tomasulo_pkg::*; #(
  parameter int RS_DEPTH   = RS_DEPTH_DEFAULT,
  parameter int MUL_STAGES = MUL_STAGES_DEFAULT
) (
  input  logic       clk_100mhz,
  input  logic       sys_rst,
  input  alu_issue_t i_alu_issue,
  input  mul_issue_t i_mul_issue,
  output logic       o_alu_ready,
  output logic       o_mul_ready,
  output cdb_t       o_cdb
);

  // alu lane
  logic         alu_disp_valid;
  tag_t         alu_disp_tag;
  data_t        alu_disp_a;
  data_t        alu_disp_b;
  alu_payload_t alu_disp_payload;
  logic         alu_fu_ready;
  logic         alu_res_valid;
  tag_t         alu_res_tag;
  data_t        alu_res_data;
  logic         alu_grant;

  // mul lane
  logic  mul_disp_valid;
  tag_t  mul_disp_tag;
  data_t mul_disp_a;
  data_t mul_disp_b;
  logic  mul_fu_ready;
  logic  mul_res_valid;
  tag_t  mul_res_tag;
  data_t mul_res_data;
  logic  mul_grant;

  reservation_station #(.payload_t(alu_payload_t), .DEPTH(RS_DEPTH)) rs_alu (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_issue_valid  (i_alu_issue.valid),
    .i_tag          (i_alu_issue.tag),
    .i_src1         (i_alu_issue.src1),
    .i_src2         (i_alu_issue.src2),
    .i_payload      (i_alu_issue.payload),
    .i_cdb          (o_cdb),  // broadcast fed back
    .i_fu_ready     (alu_fu_ready),
    .o_ready        (o_alu_ready),
    .o_disp_valid   (alu_disp_valid),
    .o_disp_tag     (alu_disp_tag),
    .o_disp_a       (alu_disp_a),
    .o_disp_b       (alu_disp_b),
    .o_disp_payload (alu_disp_payload)
  );

  alu_unit fu_alu (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .i_valid    (alu_disp_valid),
    .i_tag      (alu_disp_tag),
    .i_a        (alu_disp_a),
    .i_b        (alu_disp_b),
    .i_payload  (alu_disp_payload),
    .i_grant    (alu_grant),
    .o_ready    (alu_fu_ready),
    .o_valid    (alu_res_valid),
    .o_tag      (alu_res_tag),
    .o_result   (alu_res_data)
  );

  // mul payload bit is reserved, nothing consumes it yet
  reservation_station #(.payload_t(mul_payload_t), .DEPTH(RS_DEPTH)) rs_mul (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_issue_valid  (i_mul_issue.valid),
    .i_tag          (i_mul_issue.tag),
    .i_src1         (i_mul_issue.src1),
    .i_src2         (i_mul_issue.src2),
    .i_payload      (i_mul_issue.payload),
    .i_cdb          (o_cdb),
    .i_fu_ready     (mul_fu_ready),
    .o_ready        (o_mul_ready),
    .o_disp_valid   (mul_disp_valid),
    .o_disp_tag     (mul_disp_tag),
    .o_disp_a       (mul_disp_a),
    .o_disp_b       (mul_disp_b),
    .o_disp_payload ()
  );

  mul_unit #(.STAGES(MUL_STAGES)) fu_mul (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .i_valid    (mul_disp_valid),
    .i_tag      (mul_disp_tag),
    .i_a        (mul_disp_a),
    .i_b        (mul_disp_b),
    .i_grant    (mul_grant),
    .o_ready    (mul_fu_ready),
    .o_valid    (mul_res_valid),
    .o_tag      (mul_res_tag),
    .o_result   (mul_res_data)
  );

  cdb_arbiter arbiter (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .i_alu_valid  (alu_res_valid),
    .i_alu_tag    (alu_res_tag),
    .i_alu_result (alu_res_data),
    .i_mul_valid  (mul_res_valid),
    .i_mul_tag    (mul_res_tag),
    .i_mul_result (mul_res_data),
    .o_alu_grant  (alu_grant),
    .o_mul_grant  (mul_grant),
    .o_cdb        (o_cdb)
  );

endmodule

/* verification/tomasulo_core_properties.sv */
`timescale 1ns/1ps

module tomasulo_core_properties import tomasulo_pkg::*; #(
  parameter int RS_DEPTH = RS_DEPTH_DEFAULT
) (
  input logic       clk_100mhz,
  input logic       sys_rst,
  input alu_issue_t i_alu_issue,
  input mul_issue_t i_mul_issue,
  input logic       i_alu_disp,
  input logic       i_mul_disp,
  input logic       o_alu_ready,
  input logic       o_mul_ready,
  input cdb_t       o_cdb
);

  localparam int NTAGS = 1 << TAG_W;

  // what one tag stands for while in flight
  typedef struct packed {
    logic     is_mul;
    alu_op_t  op;
    operand_t a;
    operand_t b;
  } model_t;

  int               error_count = 0;
  logic             rst_q;
  logic [NTAGS-1:0] live;  // issued and not yet broadcast
  model_t           model [NTAGS];
  model_t           on_bus;
  data_t            expected;
  int               alu_live;
  int               mul_live;
  int               alu_held;  // accepted and not yet dispatched
  int               mul_held;

  // operand as held after the issue edge
  function automatic operand_t at_issue(operand_t op, cdb_t bus);
    if (!op.ready && bus.valid && bus.tag == op.tag) begin
      return '{ready: 1'b1, tag: op.tag, value: bus.data};
    end
    return op;
  endfunction

  function automatic data_t result_of(model_t m);
    longint prod;
    prod = longint'(m.a.value) * longint'(m.b.value);
    if (m.is_mul) return prod[XLEN-1:0];  // low word of the full product
    case (m.op)
      ALU_ADD: return m.a.value + m.b.value;
      ALU_SUB: return m.a.value - m.b.value;
      ALU_AND: return m.a.value & m.b.value;
      ALU_OR:  return m.a.value | m.b.value;
      ALU_XOR: return m.a.value ^ m.b.value;
      ALU_SLL: return m.a.value << m.b.value[4:0];
      ALU_SRL: return data_t'({m.a.value} >> m.b.value[4:0]);  // zero fill
      ALU_SLT: return (m.a.value < m.b.value) ? data_t'(1) : data_t'(0);
      default: return '0;
    endcase
  endfunction

  always_ff @(posedge clk_100mhz) begin
    rst_q <= sys_rst;
    if (sys_rst) begin
      live     <= '0;
      alu_held <= 0;
      mul_held <= 0;
    end else begin
      alu_held <= alu_held + ((i_alu_issue.valid && o_alu_ready) ? 1 : 0)
                  - (i_alu_disp ? 1 : 0);
      mul_held <= mul_held + ((i_mul_issue.valid && o_mul_ready) ? 1 : 0)
                  - (i_mul_disp ? 1 : 0);
      if (o_cdb.valid) begin
        live[o_cdb.tag] <= 1'b0;
        for (int t = 0; t < NTAGS; t++) begin
          if (!model[t].a.ready && model[t].a.tag == o_cdb.tag) begin
            model[t].a <= '{1'b1, o_cdb.tag, o_cdb.data};
          end
          if (!model[t].b.ready && model[t].b.tag == o_cdb.tag) begin
            model[t].b <= '{1'b1, o_cdb.tag, o_cdb.data};
          end
        end
      end
      if (i_alu_issue.valid && o_alu_ready) begin
        live[i_alu_issue.tag]  <= 1'b1;
        model[i_alu_issue.tag] <= '{1'b0, i_alu_issue.payload.op,
                                    at_issue(i_alu_issue.src1, o_cdb),
                                    at_issue(i_alu_issue.src2, o_cdb)};
      end
      if (i_mul_issue.valid && o_mul_ready) begin
        live[i_mul_issue.tag]  <= 1'b1;
        model[i_mul_issue.tag] <= '{1'b1, ALU_ADD,
                                    at_issue(i_mul_issue.src1, o_cdb),
                                    at_issue(i_mul_issue.src2, o_cdb)};
      end
    end
  end

  always_comb begin
    alu_live = 0;
    mul_live = 0;
    for (int t = 0; t < NTAGS; t++) begin
      if (live[t] && model[t].is_mul) mul_live++;
      if (live[t] && !model[t].is_mul) alu_live++;
    end
    on_bus   = model[o_cdb.tag];
    expected = result_of(on_bus);
  end

  a_reset_idle: assert property (@(posedge clk_100mhz)
    rst_q && !sys_rst |-> !o_cdb.valid && o_alu_ready && o_mul_ready)
    else begin
      error_count++;
      $error("bus busy or a station not ready right after reset");
    end

  a_bus_live: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_cdb.valid |-> live[o_cdb.tag])
    else begin
      error_count++;
      $error("tag %0d broadcast while not in flight", $sampled(o_cdb.tag));
    end

  a_bus_order: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_cdb.valid |-> on_bus.a.ready && on_bus.b.ready)
    else begin
      error_count++;
      $error("tag %0d broadcast before a tag it waits on", $sampled(o_cdb.tag));
    end

  a_bus_value: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_cdb.valid |-> o_cdb.data == expected)
    else begin
      error_count++;
      $error("ERROR %0t: tag %0d data %h, expected %h", $time,
             $sampled(o_cdb.tag), $sampled(o_cdb.data), $sampled(expected));
    end

  a_room: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (alu_live >= RS_DEPTH || o_alu_ready) && (mul_live >= RS_DEPTH || o_mul_ready))
    else begin
      error_count++;
      $error("station not ready although a slot must be free");
    end

  // full station drops ready, any free slot raises it
  a_full_ready: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (o_alu_ready == (alu_held < RS_DEPTH)) && (o_mul_ready == (mul_held < RS_DEPTH)))
    else begin
      error_count++;
      $error("station ready does not match the number of entries it holds");
    end

endmodule

bind tomasulo_core tomasulo_core_properties #(.RS_DEPTH(RS_DEPTH)) props (
  .clk_100mhz  (clk_100mhz),
  .sys_rst     (sys_rst),
  .i_alu_issue (i_alu_issue),
  .i_mul_issue (i_mul_issue),
  .i_alu_disp  (alu_disp_valid),
  .i_mul_disp  (mul_disp_valid),
  .o_alu_ready (o_alu_ready),
  .o_mul_ready (o_mul_ready),
  .o_cdb       (o_cdb)
);

/* verification/tb_tomasulo_core.sv */
`timescale 1ns/1ps

module tb_tomasulo_core import tomasulo_pkg::*; ();

  localparam int RS_DEPTH       = RS_DEPTH_DEFAULT;
  localparam int MUL_STAGES     = MUL_STAGES_DEFAULT;
  localparam int NUM_ISSUES     = 200;
  localparam int MUL_BURST      = 6;  // back to back multiplies first
  localparam int TIMEOUT_CYCLES = NUM_ISSUES * (MUL_STAGES + 2 + RS_DEPTH) * 4;
  localparam int NTAGS          = 1 << TAG_W;

  logic             clk_100mhz;
  logic             sys_rst;
  alu_issue_t       alu_issue;
  mul_issue_t       mul_issue;
  logic             alu_ready;
  logic             mul_ready;
  cdb_t             cdb;
  logic [NTAGS-1:0] in_flight;  // tags issued and not yet seen on the bus
  int               issued;
  int               cycles;
  int               seed;

  tomasulo_core #(.RS_DEPTH(RS_DEPTH), .MUL_STAGES(MUL_STAGES)) uut (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .i_alu_issue (alu_issue),
    .i_mul_issue (mul_issue),
    .o_alu_ready (alu_ready),
    .o_mul_ready (mul_ready),
    .o_cdb       (cdb)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  // free tag found from a random starting point
  task automatic grab_tag(output logic found, output tag_t tag);
    tag_t t;
    found = 1'b0;
    tag   = '0;
    t     = tag_t'($random(seed));
    for (int n = 0; n < NTAGS; n++) begin
      if (!found && !in_flight[t]) begin
        found = 1'b1;
        tag   = t;
      end
      t = t + tag_t'(1);
    end
  endtask

  // roughly one operand in three waits on a tag in flight
  task automatic make_operand(output operand_t op, input logic allow_wait);
    tag_t t;
    op.ready = 1'b1;
    op.tag   = '0;
    op.value = $random(seed);
    t        = tag_t'($random(seed));
    if (allow_wait && in_flight != '0 && ($unsigned($random(seed)) % 3) == 0) begin
      while (!in_flight[t]) begin
        t = t + tag_t'(1);
      end
      op.ready = 1'b0;
      op.tag   = t;
    end
  endtask

  task automatic drive_issues();
    logic       found;
    tag_t       tag;
    logic [2:0] op;
    alu_issue = '0;
    mul_issue = '0;
    if (issued < NUM_ISSUES && alu_ready && issued >= MUL_BURST
        && ($random(seed) & 3) != 0) begin
      grab_tag(found, tag);
      if (found) begin
        op = 3'($random(seed));
        alu_issue.valid      = 1'b1;
        alu_issue.tag        = tag;
        alu_issue.payload.op = alu_op_t'(op);
        make_operand(alu_issue.src1, 1'b1);
        make_operand(alu_issue.src2, 1'b1);
        in_flight[tag] = 1'b1;
        issued++;
      end
    end
    if (issued < NUM_ISSUES && mul_ready
        && (issued < MUL_BURST || ($random(seed) & 1) != 0)) begin
      grab_tag(found, tag);
      if (found) begin
        mul_issue.valid        = 1'b1;
        mul_issue.tag          = tag;
        mul_issue.payload.high = 1'b0;
        make_operand(mul_issue.src1, issued >= MUL_BURST);
        make_operand(mul_issue.src2, issued >= MUL_BURST);
        in_flight[tag] = 1'b1;
        issued++;
      end
    end
  endtask

  // tag on the bus is free again for the next cycle
  task automatic retire_broadcast();
    if (cdb.valid) begin
      in_flight[cdb.tag] = 1'b0;
    end
  endtask

  task automatic finish_run(input logic timed_out);
    int missing;
    int fails;
    missing = 0;
    for (int t = 0; t < NTAGS; t++) begin
      if (in_flight[t]) begin
        missing++;
        $display("tag %0d was issued but never broadcast", t);
      end
    end
    fails = uut.props.error_count;
    $display("errors: assertions=%0d missing_tags=%0d timeout=%0d", fails, missing, timed_out);
    if (fails == 0 && missing == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  initial begin
    seed      = 32'h15fd_9668;
    sys_rst   = 1'b1;
    alu_issue = '0;
    mul_issue = '0;
    in_flight = '0;
    issued    = 0;
    repeat (5) @(posedge clk_100mhz);
    #1;
    sys_rst = 1'b0;
    while (issued < NUM_ISSUES || in_flight != '0) begin
      @(posedge clk_100mhz);
      #1;
      drive_issues();
      retire_broadcast();  // after the drive so a same-cycle wakeup can happen
    end
    repeat (2) @(posedge clk_100mhz);  // last broadcast reaches its checks
    finish_run(1'b0);
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_100mhz);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    finish_run(1'b1);
  end

endmodule

/* build.f */
rtl/tomasulo_pkg.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/cdb_arbiter.sv
rtl/tomasulo_core.sv
verification/tomasulo_core_properties.sv
verification/tb_tomasulo_core.sv

/* Makefile */
# Verilator build and run of the Tomasulo core testbench

VERILATOR ?= verilator
TOP       ?= tb_tomasulo_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
